//--- Bender.yml
package:
  name: m6809_core

sources:
  - verilog/m6809_pkg.sv
  - verilog/m6809_decoder.sv
  - verilog/m6809_alu.sv
  - verilog/m6809_regfile.sv
  - verilog/m6809_sequencer.sv
  - verilog/m6809_core.sv
  - target: test
    files:
      - verification/m6809_tb_mem.sv
      - verification/m6809_tb.sv

//--- m6809_core.f
verilog/m6809_pkg.sv
verilog/m6809_decoder.sv
verilog/m6809_alu.sv
verilog/m6809_regfile.sv
verilog/m6809_sequencer.sv
verilog/m6809_core.sv
verification/m6809_tb_mem.sv
verification/m6809_tb.sv

//--- verification/m6809_tb.sv
// 6809 subset core testbench
module m6809_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] VEC = 16'hFFF8; // moved off the default on purpose
	localparam int CYCLE_LIMIT = 400; // per program run
	localparam int SETTLE = 60; // quiet cycles after the last expected write
	localparam int RUNS = 14;

	logic        cpu_clk;
	logic        k_reset;
	logic [7:0]  cpu_data;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_oe;
	logic        cpu_we;
	logic [7:0]  prog [$];
	integer      seed;
	int          errors;
	int          pass_count;
	int          fail_count;

	m6809_core #(
		.RESET_VECTOR(VEC)
	) UUT (
		.cpu_clk    (cpu_clk),
		.k_reset    (k_reset),
		.cpu_data_i (cpu_data),
		.cpu_addr_o (cpu_addr),
		.cpu_data_o (cpu_wdata),
		.cpu_oe_o   (cpu_oe),
		.cpu_we_o   (cpu_we)
	);

	m6809_tb_mem u_mem (
		.cpu_clk (cpu_clk),
		.addr_i  (cpu_addr),
		.wdata_i (cpu_wdata),
		.oe_i    (cpu_oe),
		.we_i    (cpu_we),
		.rdata_o (cpu_data)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #2 cpu_clk = ~cpu_clk;
	end

	initial
	begin
		#(RUNS * (CYCLE_LIMIT + SETTLE + 20) * 4 + 1000);
		$display("watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	// expected accumulator value, keyed by the opcode low nibble
	function automatic logic [7:0] alu_model(input logic [3:0] op, input logic [7:0] a,
		input logic [7:0] b);
		case (op)
			4'h0: return a - b;
			4'h4: return a & b;
			4'h8: return a ^ b;
			4'hA: return a | b;
			default: return a + b;
		endcase
	endfunction

	task automatic load_program(input logic [15:0] start);
		int i;
		@(negedge cpu_clk);
		k_reset = 1'b1;
		u_mem.clear();
		for (i = 0; i < prog.size(); i++)
			u_mem.mem[start + i] = prog[i];
		u_mem.mem[VEC] = start[15:8]; // vector high byte first
		u_mem.mem[VEC + 16'd1] = start[7:0];
	endtask

	task automatic run_program(input int n_writes);
		int cycles;
		repeat (16) @(negedge cpu_clk);
		k_reset = 1'b0;
		cycles = 0;
		while ((u_mem.wr_log.size() < n_writes) && (cycles < CYCLE_LIMIT))
		begin
			@(negedge cpu_clk);
			cycles++;
		end
		if (u_mem.wr_log.size() < n_writes)
		begin
			$display("only %0d of %0d writes seen within %0d cycles",
				u_mem.wr_log.size(), n_writes, CYCLE_LIMIT);
			errors++;
		end
		repeat (SETTLE) @(negedge cpu_clk); // a stray store would land here
		if (u_mem.wr_log.size() > n_writes)
		begin
			$display("%0d writes seen where %0d were expected", u_mem.wr_log.size(), n_writes);
			errors++;
		end
	endtask

	task automatic check_write(input int idx, input logic [15:0] addr, input logic [7:0] data);
		logic [23:0] entry;
		if (idx >= u_mem.wr_log.size())
		begin
			$display("write %0d to address %h never happened", idx, addr);
			errors++;
		end
		else
		begin
			entry = u_mem.wr_log[idx];
			if (entry[23:8] !== addr)
			begin
				$display("Mismatch cpu_addr_o write %0d expected %h actual %h", idx, addr, entry[23:8]);
				errors++;
			end
			if (entry[7:0] !== data)
			begin
				$display("Mismatch cpu_data_o write %0d expected %h actual %h", idx, data, entry[7:0]);
				errors++;
			end
		end
	endtask

	task automatic check_read(input int idx, input logic [15:0] addr);
		if (idx >= u_mem.rd_log.size())
		begin
			$display("read %0d from address %h never happened", idx, addr);
			errors++;
		end
		else if (u_mem.rd_log[idx] !== addr)
		begin
			$display("Mismatch cpu_addr_o read %0d expected %h actual %h", idx, addr,
				u_mem.rd_log[idx]);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == 0)
		begin
			pass_count++;
			$display("%s: ok", name);
		end
		else
		begin
			fail_count++;
			$display("%s: %0d errors", name, errors);
		end
		errors = 0;
	endtask

	task automatic test_reset_vector();
		prog = '{8'hB7, 8'h20, 8'h00, 8'h20, 8'hFE}; // sta $2000, bra self
		load_program(16'h4321);
		run_program(1);
		check_read(0, VEC);
		check_read(1, VEC + 16'd1);
		check_read(2, 16'h4321);
		check_write(0, 16'h2000, 8'h00);
		end_test("reset vector");
	endtask

	task automatic test_load_store();
		logic [7:0] v1;
		logic [7:0] v2;
		v1 = $random(seed);
		v2 = $random(seed);
		prog = '{8'h86, v1, 8'hB7, 8'h20, 8'h00, 8'hF6, 8'h30, 8'h00, 8'hF7, 8'h20, 8'h01,
			8'hB7, 8'h20, 8'h02, 8'h20, 8'hFE};
		load_program(16'h1000);
		u_mem.mem[16'h3000] = v2;
		run_program(3);
		check_write(0, 16'h2000, v1);
		check_write(1, 16'h2001, v2);
		check_write(2, 16'h2002, v1); // b load leaves a alone
		end_test("loads and stores");
	endtask

	task automatic test_alu();
		logic [3:0] ops [5];
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] z;
		logic [7:0] pg;
		int         i;
		int         acc;
		ops = '{4'h0, 4'h4, 4'h8, 4'hA, 4'hB}; // sub and eor or add
		for (i = 0; i < 5; i++)
		begin
			for (acc = 0; acc < 2; acc++)
			begin
				x = $random(seed);
				y = $random(seed);
				z = $random(seed);
				pg = (acc != 0) ? 8'h40 : 8'h00; // C and F pages for b
				prog = '{8'h86 | pg, x, 8'h80 | pg | ops[i], y, 8'hB7 | pg, 8'h20, 8'h00,
					8'h86 | pg, x, 8'hB0 | pg | ops[i], 8'h30, 8'h00, 8'hB7 | pg, 8'h20, 8'h01,
					8'h20, 8'hFE};
				load_program(16'h1000);
				u_mem.mem[16'h3000] = z;
				run_program(2);
				check_write(0, 16'h2000, alu_model(ops[i], x, y));
				check_write(1, 16'h2001, alu_model(ops[i], x, z));
			end
		end
		end_test("alu operations");
	endtask

	task automatic test_branches();
		logic [7:0] r;
		r = $random(seed);
		// bne falls through, beq bcs and bra each jump over one store
		prog = '{8'h86, r, 8'h80, r, 8'h26, 8'h03, 8'hB7, 8'h20, 8'h00,
			8'h27, 8'h03, 8'hB7, 8'h20, 8'h01, 8'h86, 8'h10, 8'h80, 8'h20,
			8'h25, 8'h03, 8'hB7, 8'h20, 8'h02, 8'h20, 8'h03, 8'hB7, 8'h20, 8'h03,
			8'hB7, 8'h20, 8'h04, 8'h20, 8'hFE};
		load_program(16'h1000);
		run_program(2);
		check_write(0, 16'h2000, 8'h00);
		check_write(1, 16'h2004, 8'hF0); // 10 minus 20 with borrow
		end_test("branches");
	endtask

	task automatic test_skipped_opcodes();
		logic [7:0] v;
		v = $random(seed);
		prog = '{8'h86, v, 8'h12, 8'h01, 8'h3D, 8'h87, 8'h8F, 8'h12,
			8'hB7, 8'h20, 8'h10, 8'h20, 8'hFE};
		load_program(16'h1000);
		run_program(1);
		check_write(0, 16'h2010, v);
		end_test("nop and unknown opcodes");
	endtask

	initial
	begin
		k_reset = 1'b1;
		seed = 30;
		errors = 0;
		pass_count = 0;
		fail_count = 0;
		test_reset_vector();
		test_load_store();
		test_alu();
		test_branches();
		test_skipped_opcodes();
		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- verification/m6809_tb_mem.sv
// bus memory model
module m6809_tb_mem (
	input  logic        cpu_clk,
	input  logic [15:0] addr_i,
	input  logic [7:0]  wdata_i,
	input  logic        oe_i,
	input  logic        we_i,
	output logic [7:0]  rdata_o
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0]  mem [0:65535];
	logic [23:0] wr_log [$]; // address and data of each write
	logic [15:0] rd_log [$]; // address of each read pulse

	initial
		rdata_o = 8'h00;

	always @(posedge cpu_clk)
	begin
		if (oe_i)
		begin
			rdata_o <= mem[addr_i]; // held through the cycle after oe
			rd_log.push_back(addr_i);
		end
		if (we_i)
		begin
			mem[addr_i] <= wdata_i;
			wr_log.push_back({addr_i, wdata_i});
		end
	end

	// fill from both address bytes and forget earlier bus traffic
	task automatic clear();
		int i;
		for (i = 0; i < 65536; i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'hC3;
		wr_log.delete();
		rd_log.delete();
	endtask

endmodule

//--- verilog/m6809_alu.sv
// 8-bit ALU
module m6809_alu import m6809_pkg::*; (
	input  dec_ctl_t   ctl_i,
	input  logic [7:0] acc_i,
	input  logic [7:0] operand_i,
	input  cc_t        cc_i,
	output logic [7:0] result_o,
	output cc_t        cc_o
);

	logic [8:0] sum;
	logic [8:0] diff;
	logic [7:0] res;

	assign sum  = {1'b0, acc_i} + {1'b0, operand_i};
	assign diff = {1'b0, acc_i} - {1'b0, operand_i}; // bit 8 is the borrow

	always_comb
	begin
		res    = acc_i;
		cc_o   = cc_i;
		cc_o.v = 1'b0; // logic ops, loads and stores clear v
		case (ctl_i.alu_op)
			ALU_LD: res = operand_i;
			ALU_ADD:
			begin
				res    = sum[7:0];
				cc_o.c = sum[8];
				cc_o.v = (acc_i[7] == operand_i[7]) && (sum[7] != acc_i[7]);
			end
			ALU_SUB:
			begin
				res    = diff[7:0];
				cc_o.c = diff[8];
				cc_o.v = (acc_i[7] != operand_i[7]) && (diff[7] != acc_i[7]);
			end
			ALU_AND: res = acc_i & operand_i;
			ALU_OR: res = acc_i | operand_i;
			ALU_EOR: res = acc_i ^ operand_i;
			default: res = acc_i; // store passes the accumulator
		endcase
		cc_o.n = res[7];
		cc_o.z = (res == 8'h00);
	end

	assign result_o = res;

endmodule

//--- verilog/m6809_core.sv
// 6809 subset core top level
module m6809_core import m6809_pkg::*; #(
	parameter logic [15:0] RESET_VECTOR = RESET_VECTOR_DEFAULT
) (
	input  logic        cpu_clk,
	input  logic        k_reset,
	input  logic [7:0]  cpu_data_i,
	output logic [15:0] cpu_addr_o,
	output logic [7:0]  cpu_data_o,
	output logic        cpu_oe_o,
	output logic        cpu_we_o
);

	logic [7:0] opcode;
	logic [7:0] operand;
	logic [7:0] acc;
	logic [7:0] alu_result;
	logic       acc_wr;
	dec_ctl_t   ctl;
	cc_t        cc;
	cc_t        cc_next;
	bus_req_t   bus;

	m6809_sequencer #(
		.RESET_VECTOR(RESET_VECTOR)
	) u_sequencer (
		.cpu_clk      (cpu_clk),
		.k_reset      (k_reset),
		.data_i       (cpu_data_i),
		.ctl_i        (ctl),
		.cc_i         (cc),
		.alu_result_i (alu_result),
		.opcode_o     (opcode),
		.operand_o    (operand),
		.acc_wr_o     (acc_wr),
		.bus_o        (bus)
	);

	m6809_decoder u_decoder (
		.opcode_i (opcode),
		.ctl_o    (ctl)
	);

	m6809_alu u_alu (
		.ctl_i     (ctl),
		.acc_i     (acc),
		.operand_i (operand),
		.cc_i      (cc),
		.result_o  (alu_result),
		.cc_o      (cc_next)
	);

	m6809_regfile u_regfile (
		.cpu_clk   (cpu_clk),
		.k_reset   (k_reset),
		.ctl_i     (ctl),
		.acc_wr_i  (acc_wr),
		.result_i  (alu_result),
		.cc_next_i (cc_next),
		.acc_o     (acc),
		.cc_o      (cc)
	);

	assign cpu_addr_o = bus.addr;
	assign cpu_data_o = bus.wdata;
	assign cpu_oe_o   = bus.oe;
	assign cpu_we_o   = bus.we;

endmodule

//--- verilog/m6809_decoder.sv
// opcode decoder
module m6809_decoder import m6809_pkg::*; (
	input  logic [7:0] opcode_i,
	output dec_ctl_t   ctl_o
);

	logic [3:0] hi_nib;
	logic [3:0] lo_nib;
	alu_op_e    op;
	logic       op_known;

	assign hi_nib = opcode_i[7:4];
	assign lo_nib = opcode_i[3:0];

	// low nibble picks the operation in the accumulator pages
	always_comb
	begin
		op       = ALU_LD;
		op_known = 1'b1;
		case (lo_nib)
			4'h0: op = ALU_SUB;
			4'h4: op = ALU_AND;
			4'h6: op = ALU_LD;
			4'h7: op = ALU_ST;
			4'h8: op = ALU_EOR;
			4'hA: op = ALU_OR;
			4'hB: op = ALU_ADD;
			default: op_known = 1'b0;
		endcase
	end

	always_comb
	begin
		ctl_o.mode       = MODE_NONE;
		ctl_o.acc_b      = opcode_i[6]; // C and F pages use b
		ctl_o.alu_op     = op;
		ctl_o.writes_acc = 1'b0;
		ctl_o.is_store   = 1'b0;
		ctl_o.cond       = COND_ALWAYS;
		case (hi_nib)
			4'h8, 4'hC:
				if (op_known && (op != ALU_ST)) // no store immediate
				begin
					ctl_o.mode       = MODE_IMM;
					ctl_o.writes_acc = 1'b1;
				end
			4'hB, 4'hF:
				if (op_known)
				begin
					ctl_o.mode       = MODE_EXT;
					ctl_o.writes_acc = (op != ALU_ST);
					ctl_o.is_store   = (op == ALU_ST);
				end
			4'h2:
			begin
				ctl_o.mode = MODE_REL8;
				case (lo_nib)
					4'h0: ctl_o.cond = COND_ALWAYS;
					4'h4: ctl_o.cond = COND_CC;
					4'h5: ctl_o.cond = COND_CS;
					4'h6: ctl_o.cond = COND_NE;
					4'h7: ctl_o.cond = COND_EQ;
					default: ctl_o.mode = MODE_NONE; // other branches skipped
				endcase
			end
			default: ctl_o.mode = MODE_NONE;
		endcase
	end

endmodule

//--- verilog/m6809_pkg.sv
// 6809 subset core definitions
package m6809_pkg;

	// reset vector location, high byte first
	localparam logic [15:0] RESET_VECTOR_DEFAULT = 16'hFFFE;

	typedef enum logic [2:0] {
		ALU_LD,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_ST
	} alu_op_e;

	typedef enum logic [1:0] {
		MODE_NONE, // inherent, nop or skipped opcode
		MODE_IMM,
		MODE_EXT, // 16-bit address follows
		MODE_REL8
	} addr_mode_e;

	typedef enum logic [2:0] {
		COND_ALWAYS,
		COND_NE,
		COND_EQ,
		COND_CC,
		COND_CS
	} branch_cond_e;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c; // borrow after a subtract
	} cc_t;

	typedef struct packed {
		addr_mode_e   mode;
		logic         acc_b; // 1 selects accumulator b
		alu_op_e      alu_op;
		logic         writes_acc;
		logic         is_store;
		branch_cond_e cond;
	} dec_ctl_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        oe; // one-cycle read strobe
		logic        we; // one-cycle write strobe
	} bus_req_t;

endpackage

//--- verilog/m6809_regfile.sv
// accumulators and condition codes
module m6809_regfile import m6809_pkg::*; (
	input  logic       cpu_clk,
	input  logic       k_reset,
	input  dec_ctl_t   ctl_i,
	input  logic       acc_wr_i,
	input  logic [7:0] result_i,
	input  cc_t        cc_next_i,
	output logic [7:0] acc_o,
	output cc_t        cc_o
);

	logic [7:0] acc_a_q;
	logic [7:0] acc_b_q;
	cc_t        cc_q;

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			acc_a_q <= 8'h00;
			acc_b_q <= 8'h00;
			cc_q    <= '0;
		end
		else if (acc_wr_i)
		begin
			cc_q <= cc_next_i; // stores only touch the flags
			if (ctl_i.writes_acc)
			begin
				if (ctl_i.acc_b)
					acc_b_q <= result_i;
				else
					acc_a_q <= result_i;
			end
		end
	end

	assign acc_o = ctl_i.acc_b ? acc_b_q : acc_a_q;
	assign cc_o  = cc_q;

endmodule

//--- verilog/m6809_sequencer.sv
// bus sequencer and program counter
module m6809_sequencer import m6809_pkg::*; #(
	parameter logic [15:0] RESET_VECTOR = RESET_VECTOR_DEFAULT
) (
	input  logic       cpu_clk,
	input  logic       k_reset,
	input  logic [7:0] data_i,
	input  dec_ctl_t   ctl_i,
	input  cc_t        cc_i,
	input  logic [7:0] alu_result_i,
	output logic [7:0] opcode_o,
	output logic [7:0] operand_o,
	output logic       acc_wr_o,
	output bus_req_t   bus_o
);

	typedef enum logic [3:0] {
		S_VEC_HI,
		S_VEC_LO,
		S_FETCH,
		S_DECODE,
		S_OPND,
		S_EA_HI,
		S_EA_LO,
		S_DATA,
		S_WRITE,
		S_EXEC
	} seq_state_e;

	// the three slots of a read cycle
	typedef enum logic [1:0] {
		PH_ADDR,
		PH_OE,
		PH_DATA
	} phase_e;

	seq_state_e  state_q;
	phase_e      phase_q;
	logic [7:0]  opcode_q;
	logic [7:0]  operand_q;
	logic [15:0] pc_q;
	logic [15:0] ea_q;
	logic [15:0] pc_inc;
	logic [15:0] branch_target;
	logic [15:0] vec_lo_addr;
	logic        read_state;
	logic        capture;
	logic        branch_taken;

	assign read_state = state_q inside {S_VEC_HI, S_VEC_LO, S_FETCH, S_OPND,
		S_EA_HI, S_EA_LO, S_DATA};
	assign capture = read_state && (phase_q == PH_DATA); // memory drives data_i now

	assign pc_inc        = pc_q + 16'd1;
	assign branch_target = pc_inc + {{8{data_i[7]}}, data_i}; // pc already past offset
	assign vec_lo_addr   = RESET_VECTOR + 16'd1;

	always_comb
	begin
		case (ctl_i.cond)
			COND_NE: branch_taken = !cc_i.z;
			COND_EQ: branch_taken = cc_i.z;
			COND_CC: branch_taken = !cc_i.c;
			COND_CS: branch_taken = cc_i.c;
			default: branch_taken = 1'b1;
		endcase
	end

	always_ff @(posedge cpu_clk or posedge k_reset)
	begin
		if (k_reset)
		begin
			state_q  <= S_VEC_HI;
			phase_q  <= PH_ADDR;
			opcode_q <= 8'h12; // nop until the first fetch
		end
		else
		begin
			if (read_state)
			begin
				case (phase_q)
					PH_ADDR: phase_q <= PH_OE;
					PH_OE: phase_q <= PH_DATA;
					default: phase_q <= PH_ADDR;
				endcase
			end
			case (state_q)
				S_VEC_HI:
					if (capture)
						state_q <= S_VEC_LO;
				S_VEC_LO:
					if (capture)
						state_q <= S_FETCH;
				S_FETCH:
					if (capture)
					begin
						opcode_q <= data_i;
						state_q  <= S_DECODE;
					end
				S_DECODE:
					case (ctl_i.mode)
						MODE_IMM, MODE_REL8: state_q <= S_OPND;
						MODE_EXT: state_q <= S_EA_HI;
						default: state_q <= S_FETCH; // nop and unknown opcodes
					endcase
				S_OPND:
					if (capture)
						state_q <= (ctl_i.mode == MODE_REL8) ? S_FETCH : S_EXEC;
				S_EA_HI:
					if (capture)
						state_q <= S_EA_LO;
				S_EA_LO:
					if (capture)
						state_q <= ctl_i.is_store ? S_WRITE : S_DATA;
				S_DATA:
					if (capture)
						state_q <= S_EXEC;
				S_WRITE: state_q <= S_EXEC; // exec doubles as the idle bus slot
				default: state_q <= S_FETCH;
			endcase
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		if (capture)
		begin
			case (state_q)
				S_VEC_HI: pc_q[15:8] <= data_i;
				S_VEC_LO: pc_q[7:0] <= data_i;
				S_OPND:
					if (ctl_i.mode == MODE_REL8)
						pc_q <= branch_taken ? branch_target : pc_inc;
					else
					begin
						pc_q      <= pc_inc;
						operand_q <= data_i; // immediate operand
					end
				S_EA_HI:
				begin
					pc_q       <= pc_inc;
					ea_q[15:8] <= data_i;
				end
				S_EA_LO:
				begin
					pc_q      <= pc_inc;
					ea_q[7:0] <= data_i;
				end
				S_DATA: operand_q <= data_i;
				default: pc_q <= pc_inc; // opcode fetch
			endcase
		end
	end

	always_comb
	begin
		bus_o.wdata = alu_result_i; // store data straight from the alu
		bus_o.oe    = read_state && (phase_q == PH_OE);
		bus_o.we    = (state_q == S_WRITE);
		case (state_q)
			S_VEC_HI: bus_o.addr = RESET_VECTOR;
			S_VEC_LO: bus_o.addr = vec_lo_addr;
			S_DATA, S_WRITE: bus_o.addr = ea_q;
			default: bus_o.addr = pc_q;
		endcase
	end

	assign opcode_o  = opcode_q;
	assign operand_o = operand_q;
	assign acc_wr_o  = (state_q == S_EXEC);

endmodule
